// File: tb.f
rtl/bank_pkg.sv
rtl/bank_rd_path.sv
rtl/bank_wr_path.sv
rtl/bank_arbiter.sv
rtl/bank_interleaved.sv
bench/bank_interleaved_assert.sv
bench/tb_bank_interleaved.sv

// File: run.sh
#!/bin/sh
# Build and run the banked front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_bank_interleaved \
  -f tb.f \
  -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi

exit 0

// File: bench/tb_bank_interleaved.sv
// Testbench for the banked front end that drives LFSR traffic against bank models and a shadow memory
`timescale 1ns/1ns

module tb_bank_interleaved;
  import bank_pkg::*;

  localparam int unsigned NumBanks = 4;
  localparam int unsigned RdDepth  = 4;
  localparam int unsigned MaxCycles = 4000;

  logic clk_i, arst_n_i;
  logic rd_valid_i, rd_ready_o, rd_rsp_valid_o;
  logic wr_valid_i, wr_ready_o, wr_done_o, busy_o;
  rd_req_t rd_req_i;
  wr_req_t wr_req_i;
  word_t rd_rsp_data_o;
  logic      [NumBanks-1:0] bank_req_o, bank_gnt_i, bank_rvalid_i;
  bank_req_t [NumBanks-1:0] bank_payload_o;
  word_t     [NumBanks-1:0] bank_rdata_i;

  // Bank arrays, shadow copy and expected read data
  word_t     mem [NumBanks][64];
  word_t     shadow [256];
  word_t     exp_q [$];
  logic      [NumBanks-1:0] acc_q;
  bank_req_t [NumBanks-1:0] acc_pl_q;
  logic [31:0] lfsr_q;
  int unsigned cyc, wr_acc, done_cnt;
  string test_name;

  bank_interleaved #(.NumBanks(NumBanks), .RdDepth(RdDepth)) uut (.*);

  always #2 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t s);
    word_t w;
    w = old_w;
    for (int i = 0; i < 4; i++) begin
      if (s[i]) w[i*8 +: 8] = new_w[i*8 +: 8];
    end
    return w;
  endfunction

  task automatic stop_fail(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  // Bank models answer one cycle after each granted request
  always @(posedge clk_i) begin
    acc_q    <= bank_req_o & bank_gnt_i;
    acc_pl_q <= bank_payload_o;
  end

  always @(negedge clk_i) begin
    for (int b = 0; b < NumBanks; b++) begin
      bank_rvalid_i[b] = arst_n_i && acc_q[b];
      if (arst_n_i && acc_q[b]) begin
        if (acc_pl_q[b].we) begin
          mem[b][acc_pl_q[b].row[5:0]] = merge_bytes(mem[b][acc_pl_q[b].row[5:0]],
                                                     acc_pl_q[b].wdata, acc_pl_q[b].strb);
        end else begin
          bank_rdata_i[b] = mem[b][acc_pl_q[b].row[5:0]];
        end
      end
      // Grant about three times in four
      bank_gnt_i[b] = |rand_bits(2);
    end
  end

  // Monitor and checks on the rising edge
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (cyc >= MaxCycles) stop_fail("Timeout, traffic did not finish within the cycle limit");
    if (rd_valid_i && rd_ready_o) exp_q.push_back(shadow[rd_req_i.waddr[7:0]]);
    if (wr_valid_i && wr_ready_o) begin
      shadow[wr_req_i.waddr[7:0]] = merge_bytes(shadow[wr_req_i.waddr[7:0]],
                                                wr_req_i.wdata, wr_req_i.strb);
      wr_acc = wr_acc + 1;
    end
    if (wr_done_o) done_cnt = done_cnt + 1;
    if (rd_rsp_valid_o) begin
      assert (exp_q.size() > 0) else stop_fail("Read response arrived with no read outstanding");
      assert (rd_rsp_data_o == exp_q[0]) else
        stop_fail($sformatf("Fail %s expected %h actual %h", test_name, exp_q[0], rd_rsp_data_o));
      void'(exp_q.pop_front());
    end
  end

  task automatic issue_write(input waddr_t a);
    wr_req_i.waddr = a;
    wr_req_i.wdata = rand_bits(32);
    wr_req_i.strb  = strb_t'(rand_bits(4));
    wr_valid_i     = 1'b1;
    do @(posedge clk_i); while (!wr_ready_o);
    @(negedge clk_i);
    wr_valid_i = 1'b0;
    repeat (rand_bits(2)) @(negedge clk_i);
  endtask

  task automatic issue_read(input waddr_t a);
    rd_req_i.waddr = a;
    rd_valid_i     = 1'b1;
    do @(posedge clk_i); while (!rd_ready_o);
    @(negedge clk_i);
    rd_valid_i = 1'b0;
    repeat (rand_bits(1)) @(negedge clk_i);
  endtask

  task automatic wait_idle();
    do @(negedge clk_i); while (busy_o || exp_q.size() != 0);
  endtask

  // Writes land in the upper half of bank 2 and reads in the lower half
  task automatic write_burst(input int n);
    for (int i = 0; i < n; i++) issue_write({8'h0, 1'b1, 5'(rand_bits(5)), 2'd2});
  endtask

  task automatic read_burst(input int n);
    for (int i = 0; i < n; i++) issue_read({8'h0, 1'b0, 5'(rand_bits(5)), 2'd2});
  endtask

  initial begin
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    rd_valid_i = 1'b0;
    wr_valid_i = 1'b0;
    rd_req_i = '0;
    wr_req_i = '0;
    bank_gnt_i = '0;
    bank_rvalid_i = '0;
    bank_rdata_i = '0;
    lfsr_q = 32'hf086;
    cyc = 0;
    wr_acc = 0;
    done_cnt = 0;
    // Fill pattern built from the whole word address
    for (int a = 0; a < 256; a++) begin
      shadow[a] = {16'ha5c3 ^ 16'(a), 16'(a)};
      mem[a % NumBanks][a / NumBanks] = shadow[a];
    end
    repeat (10) @(negedge clk_i);
    arst_n_i = 1'b1;

    test_name = "reset_idle";
    @(negedge clk_i);
    assert (!busy_o && bank_req_o == '0 && !rd_rsp_valid_o && !wr_done_o &&
            rd_ready_o && wr_ready_o) else stop_fail("Outputs not idle after reset");

    test_name = "write_strobes";
    for (int i = 0; i < 40; i++) issue_write({8'h0, 8'(rand_bits(8))});
    wait_idle();
    assert (done_cnt == wr_acc) else
      stop_fail($sformatf("Fail %s expected %0d actual %0d", test_name, wr_acc, done_cnt));

    test_name = "read_order";
    for (int i = 0; i < 60; i++) issue_read({8'h0, 8'(rand_bits(8))});
    wait_idle();

    test_name = "same_bank_mix";
    fork
      write_burst(20);
      read_burst(20);
    join
    wait_idle();
    assert (done_cnt == wr_acc) else
      stop_fail($sformatf("Fail %s expected %0d actual %0d", test_name, wr_acc, done_cnt));

    test_name = "drain";
    repeat (4) @(negedge clk_i);
    if (!busy_o && exp_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_fail("Design still busy or reads missing after drain");
    end
  end

endmodule

// File: bench/bank_interleaved_assert.sv
// Protocol assertions bound to the front end top level to watch its bank side and both paths
`timescale 1ns/1ns

module bank_interleaved_assert import bank_pkg::*; #(
  parameter int unsigned NumBanks = 4
) (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input logic      [NumBanks-1:0] bank_req_i,
  input bank_req_t [NumBanks-1:0] bank_payload_i,
  input logic      [NumBanks-1:0] bank_gnt_i,
  input logic      [NumBanks-1:0] bank_rvalid_i,
  input logic      [NumBanks-1:0] rd_bank_req_i,
  input logic      [NumBanks-1:0] rd_bank_gnt_i,
  input logic      [NumBanks-1:0] rd_bank_rvalid_i,
  input bank_req_t [NumBanks-1:0] rd_bank_pl_i,
  input logic      [NumBanks-1:0] wr_bank_req_i,
  input logic      [NumBanks-1:0] wr_bank_gnt_i,
  input logic      [NumBanks-1:0] wr_bank_rvalid_i,
  input bank_req_t [NumBanks-1:0] wr_bank_pl_i
);

  for (genvar b = 0; b < NumBanks; b++) begin : g_chk
    // Path request and payload hold until granted
    a_rd_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_bank_req_i[b] && !rd_bank_gnt_i[b] |=> rd_bank_req_i[b] && $stable(rd_bank_pl_i[b]))
      else $error("Read path dropped its bank request or changed the payload before grant");
    a_wr_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wr_bank_req_i[b] && !wr_bank_gnt_i[b] |=> wr_bank_req_i[b] && $stable(wr_bank_pl_i[b]))
      else $error("Write path dropped its bank request or changed the payload before grant");
    // Bank request and payload stay put until the bank grants
    a_bank_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      bank_req_i[b] && !bank_gnt_i[b] |=> bank_req_i[b] && $stable(bank_payload_i[b]))
      else $error("Bank request dropped or payload changed before the bank granted it");
    // Each answer returns to the path that the bank granted one cycle before
    a_route: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      bank_rvalid_i[b] |-> rd_bank_rvalid_i[b] == $past(rd_bank_gnt_i[b]) &&
                           wr_bank_rvalid_i[b] == $past(wr_bank_gnt_i[b]))
      else $error("Bank answer was lost or routed to a path that was not granted");
  end

endmodule

bind bank_interleaved bank_interleaved_assert #(.NumBanks(NumBanks)) u_assert (
  .clk_i            ( clk_i           ),
  .arst_n_i         ( arst_n_i        ),
  .bank_req_i       ( bank_req_o      ),
  .bank_payload_i   ( bank_payload_o  ),
  .bank_gnt_i       ( bank_gnt_i      ),
  .bank_rvalid_i    ( bank_rvalid_i   ),
  .rd_bank_req_i    ( rd_bank_req     ),
  .rd_bank_gnt_i    ( rd_bank_gnt     ),
  .rd_bank_rvalid_i ( rd_bank_rvalid  ),
  .rd_bank_pl_i     ( rd_bank_payload ),
  .wr_bank_req_i    ( wr_bank_req     ),
  .wr_bank_gnt_i    ( wr_bank_gnt     ),
  .wr_bank_rvalid_i ( wr_bank_rvalid  ),
  .wr_bank_pl_i     ( wr_bank_payload )
);

// File: rtl/bank_interleaved.sv
// Top level of the word-interleaved banked memory front end, ties both paths to per-bank arbiters
`timescale 1ns/1ns

module bank_interleaved import bank_pkg::*; #(
  parameter int unsigned NumBanks = 4,
  parameter int unsigned RdDepth  = 4
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // Read request and response
  input  logic                     rd_valid_i,
  input  rd_req_t                  rd_req_i,
  output logic                     rd_ready_o,
  output logic                     rd_rsp_valid_o,
  output word_t                    rd_rsp_data_o,
  // Write request and completion
  input  logic                     wr_valid_i,
  input  wr_req_t                  wr_req_i,
  output logic                     wr_ready_o,
  output logic                     wr_done_o,
  output logic                     busy_o,
  // Bank side
  output logic      [NumBanks-1:0] bank_req_o,
  output bank_req_t [NumBanks-1:0] bank_payload_o,
  input  logic      [NumBanks-1:0] bank_gnt_i,
  input  logic      [NumBanks-1:0] bank_rvalid_i,
  input  word_t     [NumBanks-1:0] bank_rdata_i
);

  // Read path toward the arbiters
  logic      [NumBanks-1:0] rd_bank_req, rd_bank_gnt, rd_bank_rvalid;
  bank_req_t [NumBanks-1:0] rd_bank_payload;
  // Write path toward the arbiters
  logic      [NumBanks-1:0] wr_bank_req, wr_bank_gnt, wr_bank_rvalid;
  bank_req_t [NumBanks-1:0] wr_bank_payload;
  logic                     rd_busy, wr_busy;

  assign busy_o = rd_busy | wr_busy;

  bank_rd_path #(
    .NumBanks ( NumBanks ),
    .RdDepth  ( RdDepth  )
  ) i_rd_path (
    .clk_i          ( clk_i           ),
    .arst_n_i       ( arst_n_i        ),
    .rd_valid_i     ( rd_valid_i      ),
    .rd_req_i       ( rd_req_i        ),
    .rd_ready_o     ( rd_ready_o      ),
    .rd_rsp_valid_o ( rd_rsp_valid_o  ),
    .rd_rsp_data_o  ( rd_rsp_data_o   ),
    .bank_req_o     ( rd_bank_req     ),
    .bank_payload_o ( rd_bank_payload ),
    .bank_gnt_i     ( rd_bank_gnt     ),
    .bank_rvalid_i  ( rd_bank_rvalid  ),
    // Bank data only matters to reads
    .bank_rdata_i   ( bank_rdata_i    ),
    .busy_o         ( rd_busy         )
  );

  bank_wr_path #(
    .NumBanks ( NumBanks )
  ) i_wr_path (
    .clk_i          ( clk_i           ),
    .arst_n_i       ( arst_n_i        ),
    .wr_valid_i     ( wr_valid_i      ),
    .wr_req_i       ( wr_req_i        ),
    .wr_ready_o     ( wr_ready_o      ),
    .wr_done_o      ( wr_done_o       ),
    .bank_req_o     ( wr_bank_req     ),
    .bank_payload_o ( wr_bank_payload ),
    .bank_gnt_i     ( wr_bank_gnt     ),
    .bank_rvalid_i  ( wr_bank_rvalid  ),
    .busy_o         ( wr_busy         )
  );

  // One arbiter per bank
  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    bank_arbiter i_arbiter (
      .clk_i          ( clk_i              ),
      .arst_n_i       ( arst_n_i           ),
      .rd_req_i       ( rd_bank_req[b]     ),
      .rd_payload_i   ( rd_bank_payload[b] ),
      .rd_gnt_o       ( rd_bank_gnt[b]     ),
      .rd_rvalid_o    ( rd_bank_rvalid[b]  ),
      .wr_req_i       ( wr_bank_req[b]     ),
      .wr_payload_i   ( wr_bank_payload[b] ),
      .wr_gnt_o       ( wr_bank_gnt[b]     ),
      .wr_rvalid_o    ( wr_bank_rvalid[b]  ),
      .bank_req_o     ( bank_req_o[b]      ),
      .bank_payload_o ( bank_payload_o[b]  ),
      .bank_gnt_i     ( bank_gnt_i[b]      ),
      .bank_rvalid_i  ( bank_rvalid_i[b]   )
    );
  end

endmodule

// File: rtl/bank_arbiter.sv
// Round-robin merge of the read and write paths in front of one bank with response routing
`timescale 1ns/1ns

module bank_arbiter import bank_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      rd_req_i,
  input  bank_req_t rd_payload_i,
  output logic      rd_gnt_o,
  output logic      rd_rvalid_o,
  input  logic      wr_req_i,
  input  bank_req_t wr_payload_i,
  output logic      wr_gnt_o,
  output logic      wr_rvalid_o,
  output logic      bank_req_o,
  output bank_req_t bank_payload_o,
  input  logic      bank_gnt_i,
  input  logic      bank_rvalid_i
);

  // Round-robin pointer where low gives the read path priority
  logic       rr_q;
  // Winner kept while the bank holds off the grant
  logic       lock_q;
  logic       lock_rd_q;
  logic       rd_req, wr_req;
  logic       pick_rd;
  logic       accept;

  // Route FIFO with one bit per accepted request
  // High marks the read path
  logic       route_mem_q [2];
  logic       route_wr_q, route_rd_q;
  logic [1:0] route_cnt_q;
  logic       route_full;
  logic       route_head;

  assign route_full = (route_cnt_q == 2'd2);
  assign route_head = route_mem_q[route_rd_q];

  // No new request toward the bank while routing store is full
  assign rd_req = rd_req_i && !route_full;
  assign wr_req = wr_req_i && !route_full;

  assign pick_rd        = rd_req && (lock_q ? lock_rd_q : (!wr_req || !rr_q));
  assign bank_req_o     = rd_req || wr_req;
  assign bank_payload_o = pick_rd ? rd_payload_i : wr_payload_i;

  // Grant passes through to the winner only
  assign rd_gnt_o = pick_rd && bank_gnt_i;
  assign wr_gnt_o = wr_req && !pick_rd && bank_gnt_i;
  assign accept   = bank_req_o && bank_gnt_i;

  // Answer goes back to the path recorded at the head
  assign rd_rvalid_o = bank_rvalid_i && route_head;
  assign wr_rvalid_o = bank_rvalid_i && !route_head;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q        <= 1'b0;
      lock_q      <= 1'b0;
      lock_rd_q   <= 1'b0;
      route_wr_q  <= 1'b0;
      route_rd_q  <= 1'b0;
      route_cnt_q <= '0;
    end else begin
      // After a granted conflict the losing path gets priority
      if (rd_req && wr_req && bank_gnt_i) begin
        rr_q <= pick_rd;
      end
      // Payload must not switch paths before the bank grants
      lock_q    <= bank_req_o && !bank_gnt_i;
      lock_rd_q <= pick_rd;
      if (accept) begin
        route_wr_q <= !route_wr_q;
      end
      if (bank_rvalid_i) begin
        route_rd_q <= !route_rd_q;
      end
      if (accept && !bank_rvalid_i) begin
        route_cnt_q <= route_cnt_q + 1'b1;
      end else if (!accept && bank_rvalid_i) begin
        route_cnt_q <= route_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      route_mem_q[route_wr_q] <= pick_rd;
    end
  end

endmodule

// File: rtl/bank_wr_path.sv
// Write path of the banked front end, issues one write at a time and pulses on each completion
`timescale 1ns/1ns

module bank_wr_path import bank_pkg::*; #(
  parameter int unsigned NumBanks = 4
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     wr_valid_i,
  input  wr_req_t                  wr_req_i,
  output logic                     wr_ready_o,
  output logic                     wr_done_o,
  output logic      [NumBanks-1:0] bank_req_o,
  output bank_req_t [NumBanks-1:0] bank_payload_o,
  input  logic      [NumBanks-1:0] bank_gnt_i,
  input  logic      [NumBanks-1:0] bank_rvalid_i,
  output logic                     busy_o
);

  localparam int unsigned BankBits = (NumBanks > 1) ? $clog2(NumBanks) : 1;

  // Holding slot for the write in front of the banks
  logic                slot_valid_q;
  wr_req_t             slot_q;
  logic [BankBits-1:0] slot_bank;
  logic                slot_gnt;
  logic                accept;
  bank_req_t           wr_payload;
  // Writes granted but not yet answered
  logic [1:0]          out_cnt_q;

  assign slot_bank = slot_q.waddr[BankBits-1:0];

  always_comb begin
    wr_payload.row   = slot_q.waddr >> BankBits;
    wr_payload.wdata = slot_q.wdata;
    wr_payload.strb  = slot_q.strb;
    wr_payload.we    = 1'b1;
    for (int b = 0; b < NumBanks; b++) begin
      bank_req_o[b]     = slot_valid_q && (slot_bank == BankBits'(b));
      bank_payload_o[b] = wr_payload;
    end
  end

  assign slot_gnt   = |(bank_req_o & bank_gnt_i);
  assign wr_ready_o = !slot_valid_q || slot_gnt;
  assign accept     = wr_valid_i && wr_ready_o;
  // Arbiter only steers write answers here, so any rvalid is a completion
  assign wr_done_o  = |bank_rvalid_i;
  assign busy_o     = slot_valid_q || (out_cnt_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_valid_q <= 1'b0;
      out_cnt_q    <= '0;
    end else begin
      if (accept) begin
        slot_valid_q <= 1'b1;
      end else if (slot_gnt) begin
        slot_valid_q <= 1'b0;
      end
      if (slot_gnt && !wr_done_o) begin
        out_cnt_q <= out_cnt_q + 1'b1;
      end else if (!slot_gnt && wr_done_o) begin
        out_cnt_q <= out_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_q <= wr_req_i;
    end
  end

endmodule

// File: rtl/bank_rd_path.sv
// Read path of the banked front end, issues one read at a time to a bank and returns data in order
`timescale 1ns/1ns

module bank_rd_path import bank_pkg::*; #(
  parameter int unsigned NumBanks = 4,
  parameter int unsigned RdDepth  = 4
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     rd_valid_i,
  input  rd_req_t                  rd_req_i,
  output logic                     rd_ready_o,
  output logic                     rd_rsp_valid_o,
  output word_t                    rd_rsp_data_o,
  output logic      [NumBanks-1:0] bank_req_o,
  output bank_req_t [NumBanks-1:0] bank_payload_o,
  input  logic      [NumBanks-1:0] bank_gnt_i,
  input  logic      [NumBanks-1:0] bank_rvalid_i,
  input  word_t     [NumBanks-1:0] bank_rdata_i,
  output logic                     busy_o
);

  localparam int unsigned BankBits = (NumBanks > 1) ? $clog2(NumBanks) : 1;
  localparam int unsigned PtrBits  = (RdDepth > 1) ? $clog2(RdDepth) : 1;
  localparam int unsigned CntBits  = $clog2(RdDepth + 1);

  // Holding slot for the read presented to the banks
  logic                slot_valid_q;
  waddr_t              slot_addr_q;
  logic [BankBits-1:0] slot_bank;
  logic                slot_gnt;
  logic                accept;
  bank_req_t           rd_payload;

  // Per bank, read granted but data not yet back
  logic  [NumBanks-1:0] pend_q;
  // Per bank landing register
  logic  [NumBanks-1:0] land_valid_q;
  word_t [NumBanks-1:0] land_data_q;

  // Order FIFO of bank indices, one entry per granted read
  logic [BankBits-1:0] ord_mem_q [RdDepth];
  logic [PtrBits-1:0]  ord_wr_q, ord_rd_q;
  logic [CntBits-1:0]  ord_cnt_q;
  logic                ord_full, ord_empty, ord_push, ord_pop;
  logic [BankBits-1:0] head_bank;

  assign slot_bank = slot_addr_q[BankBits-1:0];
  assign ord_full  = (ord_cnt_q == CntBits'(RdDepth));
  assign ord_empty = (ord_cnt_q == '0);
  assign head_bank = ord_mem_q[ord_rd_q];

  always_comb begin
    rd_payload       = '0;
    rd_payload.row   = slot_addr_q >> BankBits;
    for (int b = 0; b < NumBanks; b++) begin
      // Wait while the landing register of the target bank is busy
      bank_req_o[b]     = slot_valid_q && (slot_bank == BankBits'(b)) &&
                          !pend_q[b] && !land_valid_q[b] && !ord_full;
      bank_payload_o[b] = rd_payload;
    end
  end

  assign slot_gnt   = |(bank_req_o & bank_gnt_i);
  assign rd_ready_o = (!slot_valid_q || slot_gnt) && !ord_full;
  assign accept     = rd_valid_i && rd_ready_o;
  assign ord_push   = slot_gnt;

  // Head of the order FIFO decides which landing register may answer
  assign rd_rsp_valid_o = !ord_empty && land_valid_q[head_bank];
  assign rd_rsp_data_o  = land_data_q[head_bank];
  assign ord_pop        = rd_rsp_valid_o;

  assign busy_o = slot_valid_q || !ord_empty || (|land_valid_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_valid_q <= 1'b0;
      pend_q       <= '0;
      land_valid_q <= '0;
      ord_wr_q     <= '0;
      ord_rd_q     <= '0;
      ord_cnt_q    <= '0;
    end else begin
      if (accept) begin
        slot_valid_q <= 1'b1;
      end else if (slot_gnt) begin
        slot_valid_q <= 1'b0;
      end
      for (int b = 0; b < NumBanks; b++) begin
        if (bank_req_o[b] && bank_gnt_i[b]) begin
          pend_q[b] <= 1'b1;
        end else if (bank_rvalid_i[b]) begin
          pend_q[b] <= 1'b0;
        end
        if (bank_rvalid_i[b]) begin
          land_valid_q[b] <= 1'b1;
        end else if (ord_pop && (head_bank == BankBits'(b))) begin
          land_valid_q[b] <= 1'b0;
        end
      end
      if (ord_push) begin
        ord_wr_q <= (ord_wr_q == PtrBits'(RdDepth - 1)) ? '0 : ord_wr_q + 1'b1;
      end
      if (ord_pop) begin
        ord_rd_q <= (ord_rd_q == PtrBits'(RdDepth - 1)) ? '0 : ord_rd_q + 1'b1;
      end
      if (ord_push && !ord_pop) begin
        ord_cnt_q <= ord_cnt_q + 1'b1;
      end else if (!ord_push && ord_pop) begin
        ord_cnt_q <= ord_cnt_q - 1'b1;
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_addr_q <= rd_req_i.waddr;
    end
    if (ord_push) begin
      ord_mem_q[ord_wr_q] <= slot_bank;
    end
    for (int b = 0; b < NumBanks; b++) begin
      if (bank_rvalid_i[b]) begin
        land_data_q[b] <= bank_rdata_i[b];
      end
    end
  end

endmodule

// File: rtl/bank_pkg.sv
// Word, address and request types shared by the banked memory front end and its testbench
package bank_pkg;

  // One data word as stored in a bank
  typedef logic [31:0] word_t;

  // Byte enables, one bit per byte of word_t
  typedef logic [3:0] strb_t;

  // Word address
  // Low bits pick the bank, upper bits give the row inside it
  typedef logic [15:0] waddr_t;

  // Read request from the requester
  typedef struct packed {
    waddr_t waddr;
  } rd_req_t;

  // Write request from the requester
  typedef struct packed {
    waddr_t waddr;
    word_t  wdata;
    strb_t  strb;
  } wr_req_t;

  // Payload offered to a bank next to its req bit
  // Row is the word address with the bank bits shifted out
  typedef struct packed {
    waddr_t row;
    word_t  wdata;
    strb_t  strb;
    // High for a write, low for a read
    logic   we;
  } bank_req_t;

endpackage
